// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
logic/core_pkg.sv
logic/register_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/core_top.sv
test/core_assertions.sv
test/core_checker.sv
test/core_tb.sv

// File: logic/core_pkg.sv
package core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;

  typedef struct packed {
    logic [6:0]                funct7;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rs1;
    logic [2:0]                funct3;
    logic [reg_addr_width-1:0] rd;
    logic [6:0]                opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]               imm;
    logic [reg_addr_width-1:0] rs1;
    logic [2:0]                funct3;
    logic [reg_addr_width-1:0] rd;
    logic [6:0]                opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]                imm_hi;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rs1;
    logic [2:0]                funct3;
    logic [4:0]                imm_lo;
    logic [6:0]                opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                      imm_12;
    logic [5:0]                imm_10_5;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rs1;
    logic [2:0]                funct3;
    logic [3:0]                imm_4_1;
    logic                      imm_11;
    logic [6:0]                opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } instr_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt
  } alu_op_t;

  typedef enum logic [1:0] {
    fwd_none, fwd_from_mem, fwd_from_wb
  } fwd_sel_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_b_imm;
    logic    mem_rd;
    logic    mem_wr;
    logic    reg_we;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                     ctrl;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0]           rs1_data;
    logic [xlen-1:0]           rs2_data;
    logic [xlen-1:0]           imm;
  } id_ex_t;

  typedef struct packed {
    logic                      mem_rd;
    logic                      mem_wr;
    logic                      reg_we;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0]           alu_y;
    logic [xlen-1:0]           store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                      reg_we;
    logic                      mem_rd;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0]           alu_y;
    logic [xlen-1:0]           load_data;
  } mem_wb_t;

  typedef struct packed {
    logic            rd_en;
    logic            wr_en;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wr_data;
  } mem_req_t;

  typedef struct packed {
    logic                      we;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0]           data;
  } wb_t;

  // Operand source choice shared by the decode and execute stages
  function automatic logic [xlen-1:0] fwd_mux(fwd_sel_t sel, logic [xlen-1:0] reg_val,
                                              logic [xlen-1:0] mem_val,
                                              logic [xlen-1:0] wb_val);
    case (sel)
      fwd_from_mem: return mem_val;
      fwd_from_wb:  return wb_val;
      default:      return reg_val;
    endcase
  endfunction

endpackage

// File: logic/core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::instr_t    inst,
  input  logic [31:0]         rd_data,
  input  logic                mem_busy,
  output logic [31:0]         inst_addr,
  output core_pkg::mem_req_t  data_req
);
  import core_pkg::*;

  instr_t                    if_inst;
  logic [xlen-1:0]           if_pc;
  logic                      branch_taken;
  logic [xlen-1:0]           branch_target;
  logic                      stall;
  logic [reg_addr_width-1:0] rs1;
  logic [reg_addr_width-1:0] rs2;
  logic                      is_branch;
  id_ex_t                    id_ex;
  ex_mem_t                   ex_mem;
  wb_t                       wb;
  fwd_sel_t                  fwd_a_id;
  fwd_sel_t                  fwd_b_id;
  fwd_sel_t                  fwd_a_ex;
  fwd_sel_t                  fwd_b_ex;

  fetch_stage fetch_stage_i (
    .clock(clock), .reset(reset), .mem_busy(mem_busy), .stall(stall),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .inst(inst), .inst_addr(inst_addr), .if_inst(if_inst), .if_pc(if_pc)
  );

  decode_stage decode_stage_i (
    .clock(clock), .reset(reset), .mem_busy(mem_busy), .stall(stall),
    .if_inst(if_inst), .if_pc(if_pc), .wb(wb), .ex_mem(ex_mem),
    .fwd_a(fwd_a_id), .fwd_b(fwd_b_id), .rs1(rs1), .rs2(rs2), .is_branch(is_branch),
    .id_ex(id_ex), .branch_taken(branch_taken), .branch_target(branch_target)
  );

  execute_stage execute_stage_i (
    .clock(clock), .reset(reset), .mem_busy(mem_busy), .id_ex(id_ex), .wb(wb),
    .fwd_a(fwd_a_ex), .fwd_b(fwd_b_ex), .ex_mem(ex_mem)
  );

  memory_stage memory_stage_i (
    .clock(clock), .reset(reset), .mem_busy(mem_busy), .ex_mem(ex_mem),
    .rd_data(rd_data), .wb(wb)
  );

  hazard_unit hazard_unit_i (
    .rs1(rs1), .rs2(rs2), .is_branch(is_branch), .id_ex(id_ex), .ex_mem(ex_mem), .wb(wb),
    .stall(stall), .fwd_a_id(fwd_a_id), .fwd_b_id(fwd_b_id),
    .fwd_a_ex(fwd_a_ex), .fwd_b_ex(fwd_b_ex)
  );

  // Data port comes straight from EX/MEM
  assign data_req = '{rd_en: ex_mem.mem_rd, wr_en: ex_mem.mem_wr,
                      addr: ex_mem.alu_y, wr_data: ex_mem.store_data};

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 mem_busy,
  input  logic                                 stall,
  input  core_pkg::instr_t                     if_inst,
  input  logic [core_pkg::xlen-1:0]            if_pc,
  input  core_pkg::wb_t                        wb,
  input  core_pkg::ex_mem_t                    ex_mem,
  input  core_pkg::fwd_sel_t                   fwd_a,
  input  core_pkg::fwd_sel_t                   fwd_b,
  output logic [core_pkg::reg_addr_width-1:0]  rs1,
  output logic [core_pkg::reg_addr_width-1:0]  rs2,
  output logic                                 is_branch,
  output core_pkg::id_ex_t                     id_ex,
  output logic                                 branch_taken,
  output logic [core_pkg::xlen-1:0]            branch_target
);
  import core_pkg::*;

  ctrl_t           ctrl;
  logic            use_rs1;
  logic            use_rs2;
  logic            branch_ne;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;

  always_comb begin
    ctrl      = '0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    imm       = {{(xlen-12){if_inst.i_fmt.imm[11]}}, if_inst.i_fmt.imm};
    case (if_inst.r_fmt.opcode)
      op_reg: begin
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        ctrl.reg_we = 1'b1;
        case (if_inst.r_fmt.funct3)
          3'b000:  ctrl.alu_op = if_inst.r_fmt.funct7[5] ? alu_sub : alu_add;
          3'b010:  ctrl.alu_op = alu_slt;
          3'b100:  ctrl.alu_op = alu_xor;
          3'b110:  ctrl.alu_op = alu_or;
          3'b111:  ctrl.alu_op = alu_and;
          default: ctrl.reg_we = 1'b0;
        endcase
      end
      op_imm: begin
        use_rs1        = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.reg_we    = 1'b1;
        case (if_inst.i_fmt.funct3)
          3'b000:  ctrl.alu_op = alu_add;
          3'b100:  ctrl.alu_op = alu_xor;
          3'b110:  ctrl.alu_op = alu_or;
          3'b111:  ctrl.alu_op = alu_and;
          default: ctrl.reg_we = 1'b0;
        endcase
      end
      op_load: begin
        if (if_inst.i_fmt.funct3 == 3'b010) begin
          use_rs1        = 1'b1;
          ctrl.alu_b_imm = 1'b1;
          ctrl.mem_rd    = 1'b1;
          ctrl.reg_we    = 1'b1;
        end
      end
      op_store: begin
        imm = {{(xlen-12){if_inst.s_fmt.imm_hi[6]}}, if_inst.s_fmt.imm_hi, if_inst.s_fmt.imm_lo};
        if (if_inst.s_fmt.funct3 == 3'b010) begin
          use_rs1        = 1'b1;
          use_rs2        = 1'b1;
          ctrl.alu_b_imm = 1'b1;
          ctrl.mem_wr    = 1'b1;
        end
      end
      op_branch: begin
        // BEQ and BNE only differ in funct3 bit 0
        if (if_inst.b_fmt.funct3[2:1] == 2'b00) begin
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
          is_branch = 1'b1;
          branch_ne = if_inst.b_fmt.funct3[0];
        end
      end
      default: ;
    endcase
  end

  // Unused source fields read as x0 so the hazard unit sees no false match
  assign rs1 = use_rs1 ? if_inst.r_fmt.rs1 : '0;
  assign rs2 = use_rs2 ? if_inst.r_fmt.rs2 : '0;

  register_file register_file_i (
    .clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2), .wb(wb),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign op_a = fwd_mux(fwd_a, rs1_data, ex_mem.alu_y, wb.data);
  assign op_b = fwd_mux(fwd_b, rs2_data, ex_mem.alu_y, wb.data);

  assign imm_b = {{(xlen-12){if_inst.b_fmt.imm_12}}, if_inst.b_fmt.imm_11,
                  if_inst.b_fmt.imm_10_5, if_inst.b_fmt.imm_4_1, 1'b0};
  assign branch_target = if_pc + imm_b;
  assign branch_taken  = is_branch && !stall && ((op_a == op_b) != branch_ne);

  always_ff @(posedge clock) begin
    if (reset) begin
      id_ex <= '0;
    end else if (!mem_busy) begin
      if (stall) begin
        id_ex <= '0;
      end else begin
        id_ex <= '{ctrl: ctrl, rs1: rs1, rs2: rs2, rd: if_inst.r_fmt.rd,
                   rs1_data: op_a, rs2_data: op_b, imm: imm};
      end
    end
  end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               mem_busy,
  input  core_pkg::id_ex_t   id_ex,
  input  core_pkg::wb_t      wb,
  input  core_pkg::fwd_sel_t fwd_a,
  input  core_pkg::fwd_sel_t fwd_b,
  output core_pkg::ex_mem_t  ex_mem
);
  import core_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b_reg;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_y;

  assign op_a     = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.alu_y, wb.data);
  assign op_b_reg = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.alu_y, wb.data);
  assign op_b     = id_ex.ctrl.alu_b_imm ? id_ex.imm : op_b_reg;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_sub: alu_y = op_a - op_b;
      alu_and: alu_y = op_a & op_b;
      alu_or:  alu_y = op_a | op_b;
      alu_xor: alu_y = op_a ^ op_b;
      alu_slt: alu_y = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_y = op_a + op_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_mem <= '0;
    end else if (!mem_busy) begin
      // Store data is the rs2 value after forwarding
      ex_mem <= '{mem_rd: id_ex.ctrl.mem_rd, mem_wr: id_ex.ctrl.mem_wr,
                  reg_we: id_ex.ctrl.reg_we, rd: id_ex.rd,
                  alu_y: alu_y, store_data: op_b_reg};
    end
  end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    mem_busy,
  input  logic                    stall,
  input  logic                    branch_taken,
  input  logic [core_pkg::xlen-1:0] branch_target,
  input  core_pkg::instr_t        inst,
  output logic [core_pkg::xlen-1:0] inst_addr,
  output core_pkg::instr_t        if_inst,
  output logic [core_pkg::xlen-1:0] if_pc
);
  import core_pkg::*;

  logic [xlen-1:0] pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc      <= '0;
      if_inst <= '0;
      if_pc   <= '0;
    end else if (!mem_busy && !stall) begin
      if (branch_taken) begin
        // Drop the word fetched behind the branch
        pc      <= branch_target;
        if_inst <= '0;
      end else begin
        pc      <= pc + xlen'(4);
        if_inst <= inst;
      end
      if_pc <= pc;
    end
  end

  assign inst_addr = pc;

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  logic [core_pkg::reg_addr_width-1:0] rs1,
  input  logic [core_pkg::reg_addr_width-1:0] rs2,
  input  logic                                is_branch,
  input  core_pkg::id_ex_t                    id_ex,
  input  core_pkg::ex_mem_t                   ex_mem,
  input  core_pkg::wb_t                       wb,
  output logic                                stall,
  output core_pkg::fwd_sel_t                  fwd_a_id,
  output core_pkg::fwd_sel_t                  fwd_b_id,
  output core_pkg::fwd_sel_t                  fwd_a_ex,
  output core_pkg::fwd_sel_t                  fwd_b_ex
);
  import core_pkg::*;

  logic ex_hit;
  logic mem_load_hit;

  function automatic fwd_sel_t pick(logic [reg_addr_width-1:0] rs, logic mem_ok,
                                    logic [reg_addr_width-1:0] mem_rd,
                                    logic wb_we, logic [reg_addr_width-1:0] wb_rd);
    if (rs != '0 && mem_ok && mem_rd == rs) return fwd_from_mem;
    if (rs != '0 && wb_we && wb_rd == rs) return fwd_from_wb;
    return fwd_none;
  endfunction

  // A load in MEM only has its address on alu_y, so decode never takes it
  assign fwd_a_id = pick(rs1, ex_mem.reg_we && !ex_mem.mem_rd, ex_mem.rd, wb.we, wb.rd);
  assign fwd_b_id = pick(rs2, ex_mem.reg_we && !ex_mem.mem_rd, ex_mem.rd, wb.we, wb.rd);
  assign fwd_a_ex = pick(id_ex.rs1, ex_mem.reg_we, ex_mem.rd, wb.we, wb.rd);
  assign fwd_b_ex = pick(id_ex.rs2, ex_mem.reg_we, ex_mem.rd, wb.we, wb.rd);

  assign ex_hit = id_ex.ctrl.reg_we && id_ex.rd != '0 &&
                  (id_ex.rd == rs1 || id_ex.rd == rs2);
  assign mem_load_hit = ex_mem.mem_rd && ex_mem.rd != '0 &&
                        (ex_mem.rd == rs1 || ex_mem.rd == rs2);

  // Branches compare in decode and need results one stage earlier
  assign stall = (ex_hit && id_ex.ctrl.mem_rd) ||
                 (is_branch && ex_hit) ||
                 (is_branch && mem_load_hit);

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      mem_busy,
  input  core_pkg::ex_mem_t         ex_mem,
  input  logic [core_pkg::xlen-1:0] rd_data,
  output core_pkg::wb_t             wb
);
  import core_pkg::*;

  mem_wb_t mem_wb;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_wb <= '0;
    end else if (!mem_busy) begin
      mem_wb <= '{reg_we: ex_mem.reg_we, mem_rd: ex_mem.mem_rd, rd: ex_mem.rd,
                  alu_y: ex_mem.alu_y, load_data: rd_data};
    end
  end

  // Writeback source
  assign wb.we   = mem_wb.reg_we;
  assign wb.rd   = mem_wb.rd;
  assign wb.data = mem_wb.mem_rd ? mem_wb.load_data : mem_wb.alu_y;

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [core_pkg::reg_addr_width-1:0] rs1,
  input  logic [core_pkg::reg_addr_width-1:0] rs2,
  input  core_pkg::wb_t                       wb,
  output logic [core_pkg::xlen-1:0]           rs1_data,
  output logic [core_pkg::xlen-1:0]           rs2_data
);
  import core_pkg::*;

  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: test/core_assertions.sv
`timescale 1ns/1ps

module core_assertions (
  input logic               clock,
  input logic               reset,
  input logic               mem_busy,
  input logic [31:0]        inst_addr,
  input core_pkg::mem_req_t data_req
);

  int failures = 0;

  outputs_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown({inst_addr, data_req}))
    else begin
      $error("core outputs carry X or Z after reset");
      failures++;
    end

  one_enable: assert property (@(posedge clock) disable iff (reset)
    !(data_req.rd_en && data_req.wr_en))
    else begin
      $error("data_req has rd_en and wr_en high together");
      failures++;
    end

  // The whole pipeline freezes while busy
  busy_hold: assert property (@(posedge clock) disable iff (reset)
    mem_busy |=> $stable(data_req))
    else begin
      $error("data_req changed across a busy cycle");
      failures++;
    end

endmodule

bind core_top core_assertions core_assertions_i (
  .clock(clock), .reset(reset), .mem_busy(mem_busy),
  .inst_addr(inst_addr), .data_req(data_req)
);

// File: test/core_checker.sv
`timescale 1ns/1ps

module core_checker (
  input  logic               clock,
  input  logic               reset,
  input  logic               mem_busy,
  input  logic               done,
  input  logic [31:0]        inst_addr,
  input  core_pkg::mem_req_t data_req,
  input  logic [31:0]        program_words [256],
  input  logic [31:0]        init_data [64],
  output int                 value_errors,
  output int                 other_errors,
  output int                 stores_seen,
  output int                 stores_expected
);
  import core_pkg::*;

  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_load [$];
  int          loads_seen;
  int          loads_expected;
  mem_req_t    last_req;
  bit          last_busy;
  bit          reset_checked;
  bit          final_checked;
  bit          model_halted;

  // ISA-level run of the program that collects every store and load in order
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [64];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] opnd;
    logic [31:0] y;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    int          pc;
    int          pc_next;
    int          steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 64; i++) mem[i] = init_data[i];
    pc = 0;
    steps = 0;
    while (!model_halted && steps < 2000 && pc >= 0 && pc < 256) begin
      w = program_words[pc];
      a = regs[w[19:15]];
      b = regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      pc_next = pc + 1;
      case (w[6:0])
        op_reg, op_imm: begin
          opnd = (w[6:0] == op_reg) ? b : imm_i;
          case (w[14:12])
            3'b000:  y = (w[6:0] == op_reg && w[30]) ? a - opnd : a + opnd;
            3'b010:  y = ($signed(a) < $signed(opnd)) ? 32'd1 : 32'd0;
            3'b100:  y = a ^ opnd;
            3'b110:  y = a | opnd;
            default: y = a & opnd;
          endcase
          regs[w[11:7]] = y;
        end
        op_load: begin
          y = a + imm_i;
          regs[w[11:7]] = mem[y[7:2]];
          exp_load.push_back(y);
        end
        op_store: begin
          y = a + imm_s;
          mem[y[7:2]] = b;
          exp_addr.push_back(y);
          exp_data.push_back(b);
        end
        op_branch: begin
          if ((a == b) != w[12]) begin
            // A taken branch onto itself is the halt loop
            if (imm_b == '0) model_halted = 1'b1;
            pc_next = pc + int'($signed(imm_b) >>> 2);
          end
        end
        default: ;
      endcase
      regs[0] = '0;
      pc = pc_next;
      steps++;
    end
  endtask

  task automatic check_store();
    if (exp_addr.size() == 0) begin
      other_errors++;
      $display("At %0t ns the core stored to %h, a store the model never made",
               $time, data_req.addr);
    end else begin
      if (data_req.addr != exp_addr[0]) begin
        value_errors++;
        $display("ERROR at %0t ns: data_req.addr got %h, expected %h",
                 $time, data_req.addr, exp_addr[0]);
      end
      if (data_req.wr_data != exp_data[0]) begin
        value_errors++;
        $display("ERROR at %0t ns: data_req.wr_data got %h, expected %h",
                 $time, data_req.wr_data, exp_data[0]);
      end
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
    end
    stores_seen++;
  endtask

  task automatic check_load();
    if (exp_load.size() == 0) begin
      other_errors++;
      $display("At %0t ns the core read from %h, a load the model never made",
               $time, data_req.addr);
    end else begin
      if (data_req.addr != exp_load[0]) begin
        value_errors++;
        $display("ERROR at %0t ns: data_req.addr got %h, expected %h",
                 $time, data_req.addr, exp_load[0]);
      end
      void'(exp_load.pop_front());
    end
    loads_seen++;
  endtask

  initial begin
    @(posedge clock);
    run_model();
    stores_expected = exp_addr.size();
    loads_expected  = exp_load.size();
  end

  // Sampled on the falling edge where outputs are stable
  always @(negedge clock) begin
    if (reset) begin
      value_errors = 0;
      other_errors = 0;
      stores_seen  = 0;
      loads_seen   = 0;
    end else if (!done) begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (inst_addr != '0) begin
          value_errors++;
          $display("ERROR at %0t ns: inst_addr got %h, expected %h", $time, inst_addr, 32'd0);
        end
        if (data_req.rd_en || data_req.wr_en) begin
          value_errors++;
          $display("ERROR at %0t ns: data_req enables got %b%b, expected 00",
                   $time, data_req.rd_en, data_req.wr_en);
        end
      end else if (last_busy && data_req != last_req) begin
        value_errors++;
        $display("ERROR at %0t ns: data_req got %h, expected %h", $time, data_req, last_req);
      end
      if (data_req.wr_en && !mem_busy) check_store();
      if (data_req.rd_en && !mem_busy) check_load();
      last_req  = data_req;
      last_busy = mem_busy;
    end else if (!final_checked) begin
      final_checked = 1'b1;
      if (!model_halted) begin
        other_errors++;
        $display("The reference model never reached the halt loop");
      end
      if (stores_seen != stores_expected) begin
        other_errors++;
        $display("The core made %0d stores but the model made %0d", stores_seen, stores_expected);
      end
      if (loads_seen != loads_expected) begin
        other_errors++;
        $display("The core made %0d loads but the model made %0d", loads_seen, loads_expected);
      end
    end
  end

endmodule

// File: test/core_tb.sv
`timescale 1ns/1ps

module core_tb;
  import core_pkg::*;

  localparam int body_length    = 200;
  localparam int halt_index     = body_length + 31;
  localparam int halt_fetches   = 20;
  localparam int timeout_cycles = body_length * 8 + 100;

  logic        clock;
  logic        reset;
  logic        mem_busy;
  logic        done;
  instr_t      inst;
  logic [31:0] rd_data;
  logic [31:0] inst_addr;
  mem_req_t    data_req;
  logic [31:0] rng;
  logic [31:0] program_words [256];
  logic [31:0] init_data [64];
  logic [31:0] data_mem [64];
  int          cycles;
  int          halt_hits;
  int          value_errors;
  int          other_errors;
  int          stores_seen;
  int          stores_expected;

  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Steps the generator and returns 0 to limit-1
  function automatic int rand_below(int limit);
    rng = lcg_next(rng);
    return int'((rng >> 8) % 32'(limit));
  endfunction

  // Only x0 to x7 for dense dependencies
  function automatic logic [4:0] small_reg();
    return 5'(rand_below(8));
  endfunction

  function automatic logic [31:0] reg_word(logic [6:0] funct7, logic [2:0] funct3,
                                           logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, op_reg};
  endfunction

  function automatic logic [31:0] imm_word(logic [6:0] opcode, logic [2:0] funct3,
                                           logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic logic [31:0] store_word(logic [4:0] rs2, logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] branch_word(logic [2:0] funct3, logic [4:0] rs1,
                                              logic [4:0] rs2, logic [12:0] offset);
    return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], op_branch};
  endfunction

  task automatic build_program();
    int         kind;
    int         sel;
    int         skip;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] offset;
    for (int i = 0; i < 256; i++) program_words[i] = '0;
    for (int i = 0; i < body_length; i++) begin
      rd     = small_reg();
      rs1    = small_reg();
      rs2    = small_reg();
      offset = 12'(4 * rand_below(64));
      kind   = rand_below(8);
      sel    = rand_below(6);
      case (sel)
        0, 1:    funct3 = 3'b000;
        2:       funct3 = 3'b111;
        3:       funct3 = 3'b110;
        4:       funct3 = 3'b100;
        default: funct3 = (kind < 2) ? 3'b010 : 3'b000;
      endcase
      case (kind)
        0, 1: program_words[i] = reg_word(sel == 1 ? 7'h20 : 7'h00, funct3, rd, rs1, rs2);
        2, 3: program_words[i] = imm_word(op_imm, funct3, rd, rs1, 12'(rand_below(4096)));
        4:    program_words[i] = imm_word(op_load, 3'b010, rd, 5'd0, offset);
        5:    program_words[i] = store_word(rs2, offset);
        default: begin
          // Forward only and never past the closing stores
          skip = 1 + rand_below(4);
          if (i + skip > body_length) skip = body_length - i;
          program_words[i] = branch_word(3'(rand_below(2)), rs1, rs2, 13'(4 * skip));
        end
      endcase
    end
    for (int r = 1; r < 32; r++) begin
      program_words[body_length + r - 1] = store_word(5'(r), 12'(4 * r));
    end
    program_words[halt_index] = branch_word(3'b000, 5'd0, 5'd0, 13'd0);
    for (int i = 0; i < 64; i++) begin
      rng = lcg_next(rng);
      init_data[i] = rng;
    end
  endtask

  core_top core_top_i (
    .clock(clock), .reset(reset), .inst(inst), .rd_data(rd_data), .mem_busy(mem_busy),
    .inst_addr(inst_addr), .data_req(data_req)
  );

  core_checker core_checker_i (
    .clock(clock), .reset(reset), .mem_busy(mem_busy), .done(done),
    .inst_addr(inst_addr), .data_req(data_req), .program_words(program_words),
    .init_data(init_data), .value_errors(value_errors), .other_errors(other_errors),
    .stores_seen(stores_seen), .stores_expected(stores_expected)
  );

  // Both memories answer within the cycle
  assign inst    = program_words[inst_addr[9:2]];
  assign rd_data = data_mem[data_req.addr[7:2]];

  always @(posedge clock) begin
    if (reset) begin
      data_mem <= init_data;
    end else if (data_req.wr_en && !mem_busy) begin
      data_mem[data_req.addr[7:2]] <= data_req.wr_data;
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      cycles    <= 0;
      halt_hits <= 0;
    end else begin
      cycles <= cycles + 1;
      if (!mem_busy && inst_addr == 32'(halt_index * 4)) halt_hits <= halt_hits + 1;
    end
  end

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Busy about one cycle in four
  initial begin
    mem_busy = 1'b0;
    forever begin
      @(posedge clock);
      if (reset) mem_busy <= 1'b0;
      else mem_busy <= (rand_below(4) == 0);
    end
  end

  initial begin
    rng   = 32'hdd5c_03a6;
    reset = 1'b1;
    done  = 1'b0;
    build_program();
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    while (halt_hits < halt_fetches && cycles < timeout_cycles) begin
      @(posedge clock);
    end
    done <= 1'b1;
    repeat (2) @(negedge clock);
    if (halt_hits < halt_fetches) begin
      $display("Timeout: the halt loop was reached %0d times in %0d cycles", halt_hits, cycles);
    end
    $display({"Stores %0d of %0d, value errors %0d, other errors %0d, ",
              "assertion failures %0d, timeouts %0d"},
             stores_seen, stores_expected, value_errors, other_errors,
             core_top_i.core_assertions_i.failures,
             (halt_hits < halt_fetches) ? 1 : 0);
    if (halt_hits >= halt_fetches && value_errors == 0 && other_errors == 0 &&
        core_top_i.core_assertions_i.failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
